//--- source/i2c_pkg.sv
package i2c_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // clock and bus timing
    ////////////////////////////////////////////////////////////////////////////

    // 100 MHz system clock
    localparam int CLKS_PER_USEC = 100;
    // 5 us half period, 100 kHz scl
    localparam int SCL_HALF_USEC = 5;

    localparam int ADDR_W = 7;
    localparam int BYTE_W = 8;

    localparam int USEC_CNT_W = $clog2(CLKS_PER_USEC);
    localparam int SCL_CNT_W  = $clog2(SCL_HALF_USEC);
    localparam int BIT_IDX_W  = $clog2(BYTE_W);

    localparam logic [USEC_CNT_W-1:0] USEC_LAST   = USEC_CNT_W'(CLKS_PER_USEC - 1);
    localparam logic [SCL_CNT_W-1:0]  SCL_LAST    = SCL_CNT_W'(SCL_HALF_USEC - 1);
    // sda release point in the stop state, one tick before scl would toggle
    localparam logic [SCL_CNT_W-1:0]  SCL_STOP_AT = SCL_CNT_W'(SCL_HALF_USEC - 2);
    localparam logic [BIT_IDX_W-1:0]  BIT_MSB     = BIT_IDX_W'(BYTE_W - 1);

    // write-only master states
    typedef enum logic [2:0] {
        i2c_idle,
        i2c_start,
        i2c_send_addr,
        i2c_ack,
        i2c_send_data,
        i2c_scl_stop,
        i2c_stop
    } i2c_state_e;

endpackage

//--- source/lcd_pkg.sv
package lcd_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // frame timing
    ////////////////////////////////////////////////////////////////////////////

    // spacing between frame strobes, longer than one bus frame
    localparam int FRAME_USEC      = 200;
    // two frames per nibble plus a closing disabled frame
    localparam int FRAMES_PER_BYTE = 5;

    localparam int FRAME_CNT_W = $clog2(FRAME_USEC);
    localparam int FRAME_IDX_W = $clog2(FRAMES_PER_BYTE + 1);

    localparam logic [FRAME_CNT_W-1:0] FRAME_LAST  = FRAME_CNT_W'(FRAME_USEC - 1);
    localparam logic [FRAME_IDX_W-1:0] FRAMES_DONE = FRAME_IDX_W'(FRAMES_PER_BYTE);

    ////////////////////////////////////////////////////////////////////////////
    // expander low bits: backlight, en, rw (rs goes below them)
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [2:0] CTRL_DISABLE = 3'b100;
    localparam logic [2:0] CTRL_ENABLE  = 3'b110;

    // one state per frame of a byte
    typedef enum logic [2:0] {
        snd_idle,
        snd_high_off,
        snd_high_on,
        snd_low_off,
        snd_low_on,
        snd_tail_off
    } send_state_e;

endpackage

//--- source/i2c_req_if.sv
interface i2c_req_if;

    // frame request, addr and data valid with the start strobe
    logic [i2c_pkg::ADDR_W-1:0] addr;
    logic [i2c_pkg::BYTE_W-1:0] data;
    logic                       start;
    // high while the master owns the bus
    logic                       busy;

    modport sender (
        output addr, data, start,
        input  busy
    );

    modport master (
        input  addr, data, start,
        output busy
    );

endinterface

//--- source/usec_tick.sv
module usec_tick (
    input  logic clk,
    input  logic reset_p,
    output logic usec
);

    logic [i2c_pkg::USEC_CNT_W-1:0] clk_cnt;

    // free running divider
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            clk_cnt <= '0;
        end else if (clk_cnt == i2c_pkg::USEC_LAST) begin
            clk_cnt <= '0;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // one cycle strobe on wrap
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            usec <= 1'b0;
        end else begin
            usec <= (clk_cnt == i2c_pkg::USEC_LAST);
        end
    end

endmodule

//--- source/i2c_master.sv
module i2c_master (
    input  logic      clk,
    input  logic      reset_p,
    input  logic      usec,
    i2c_req_if.master req,
    output logic      scl,
    output logic      sda
);

    i2c_pkg::i2c_state_e state;

    logic                            scl_en;
    logic                            scl_d;
    logic                            scl_fall;
    logic                            scl_rise;
    logic [i2c_pkg::SCL_CNT_W-1:0]   scl_cnt;
    logic [i2c_pkg::BIT_IDX_W-1:0]   bit_idx;
    logic [i2c_pkg::BYTE_W-1:0]      addr_byte;
    logic [i2c_pkg::BYTE_W-1:0]      data_byte;
    logic [i2c_pkg::BYTE_W-1:0]      tx_byte;
    logic                            data_done;

    ////////////////////////////////////////////////////////////////////////////
    // scl generator
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            scl_cnt <= '0;
            scl     <= 1'b1;
        end else if (!scl_en) begin
            scl_cnt <= '0;
            scl     <= 1'b1;
        end else if (usec) begin
            if (scl_cnt == i2c_pkg::SCL_LAST) begin
                scl_cnt <= '0;
                scl     <= ~scl;
            end else begin
                scl_cnt <= scl_cnt + 1'b1;
            end
        end
    end

    // edges seen one cycle late, so sda moves after scl has settled low
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            scl_d <= 1'b1;
        end else begin
            scl_d <= scl;
        end
    end

    assign scl_fall = scl_d & ~scl;
    assign scl_rise = ~scl_d & scl;

    assign req.busy = (state != i2c_pkg::i2c_idle);
    assign tx_byte  = (state == i2c_pkg::i2c_send_data) ? data_byte : addr_byte;

    // request capture, write bit is always 0
    always_ff @(posedge clk) begin
        if (state == i2c_pkg::i2c_idle && req.start) begin
            addr_byte <= {req.addr, 1'b0};
            data_byte <= req.data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            state     <= i2c_pkg::i2c_idle;
            scl_en    <= 1'b0;
            sda       <= 1'b1;
            bit_idx   <= i2c_pkg::BIT_MSB;
            data_done <= 1'b0;
        end else begin
            case (state)
                i2c_pkg::i2c_idle: begin
                    if (req.start) state <= i2c_pkg::i2c_start;
                end
                // start condition, sda falls with scl high
                i2c_pkg::i2c_start: begin
                    sda       <= 1'b0;
                    scl_en    <= 1'b1;
                    bit_idx   <= i2c_pkg::BIT_MSB;
                    data_done <= 1'b0;
                    state     <= i2c_pkg::i2c_send_addr;
                end
                i2c_pkg::i2c_send_addr, i2c_pkg::i2c_send_data: begin
                    if (scl_fall) sda <= tx_byte[bit_idx];
                    if (scl_rise) begin
                        if (bit_idx == '0) begin
                            bit_idx <= i2c_pkg::BIT_MSB;
                            state   <= i2c_pkg::i2c_ack;
                        end else begin
                            bit_idx <= bit_idx - 1'b1;
                        end
                    end
                end
                // no read path, slot is driven high and not sampled
                i2c_pkg::i2c_ack: begin
                    if (scl_fall) sda <= 1'b1;
                    if (scl_rise) begin
                        if (data_done) begin
                            state <= i2c_pkg::i2c_scl_stop;
                        end else begin
                            data_done <= 1'b1;
                            state     <= i2c_pkg::i2c_send_data;
                        end
                    end
                end
                i2c_pkg::i2c_scl_stop: begin
                    if (scl_fall) sda <= 1'b0;
                    if (scl_rise) state <= i2c_pkg::i2c_stop;
                end
                // stop condition, sda rises with scl high
                i2c_pkg::i2c_stop: begin
                    if (usec && scl_cnt == i2c_pkg::SCL_STOP_AT) begin
                        sda    <= 1'b1;
                        scl_en <= 1'b0;
                        state  <= i2c_pkg::i2c_idle;
                    end
                end
                default: state <= i2c_pkg::i2c_idle;
            endcase
        end
    end

    a_sda_stable_scl_high: assert property (@(posedge clk) disable iff (reset_p)
        (scl && $past(scl) && $changed(sda)) |->
        ($past(state) == i2c_pkg::i2c_start || $past(state) == i2c_pkg::i2c_stop))
        else $error("sda moved while scl high outside start/stop");

    // a new request only ever arrives once the previous frame has ended
    a_start_from_idle: assert property (@(posedge clk) disable iff (reset_p)
        req.start |-> (state == i2c_pkg::i2c_idle))
        else $error("start strobe while a frame is in progress");

endmodule

//--- source/lcd_byte_sender.sv
module lcd_byte_sender (
    input  logic                       clk,
    input  logic                       reset_p,
    input  logic                       usec,
    input  logic                       send,
    input  logic [i2c_pkg::BYTE_W-1:0] send_byte,
    input  logic                       rs,
    input  logic [i2c_pkg::ADDR_W-1:0] addr,
    i2c_req_if.sender                  req,
    output logic                       busy
);

    lcd_pkg::send_state_e state;
    lcd_pkg::send_state_e next_state;

    logic [i2c_pkg::BYTE_W-1:0]     byte_q;
    logic                           rs_q;
    logic [i2c_pkg::ADDR_W-1:0]     addr_q;
    logic                           start_q;
    logic [lcd_pkg::FRAME_CNT_W-1:0] frame_timer;
    logic [lcd_pkg::FRAME_IDX_W-1:0] frame_cnt;
    logic [i2c_pkg::BYTE_W/2-1:0]   nibble;
    logic [2:0]                     ctrl;

    always_ff @(posedge clk) begin
        if (state == lcd_pkg::snd_idle && send) begin
            byte_q <= send_byte;
            rs_q   <= rs;
            addr_q <= addr;
        end
    end

    // frame order within a byte
    always_comb begin
        case (state)
            lcd_pkg::snd_high_off: next_state = lcd_pkg::snd_high_on;
            lcd_pkg::snd_high_on:  next_state = lcd_pkg::snd_low_off;
            lcd_pkg::snd_low_off:  next_state = lcd_pkg::snd_low_on;
            lcd_pkg::snd_low_on:   next_state = lcd_pkg::snd_tail_off;
            default:               next_state = lcd_pkg::snd_idle;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // frame sequencer, one start strobe per FRAME_USEC
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            state       <= lcd_pkg::snd_idle;
            start_q     <= 1'b0;
            frame_timer <= '0;
        end else begin
            start_q <= 1'b0;
            if (state == lcd_pkg::snd_idle) begin
                // send while busy never reaches here
                if (send) begin
                    state       <= lcd_pkg::snd_high_off;
                    start_q     <= 1'b1;
                    frame_timer <= '0;
                end
            end else if (usec) begin
                if (frame_timer == lcd_pkg::FRAME_LAST) begin
                    frame_timer <= '0;
                    state       <= next_state;
                    start_q     <= (next_state != lcd_pkg::snd_idle);
                end else begin
                    frame_timer <= frame_timer + 1'b1;
                end
            end
        end
    end

    // frames issued for the current byte
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            frame_cnt <= '0;
        end else if (state == lcd_pkg::snd_idle && send) begin
            frame_cnt <= '0;
        end else if (start_q) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    assign nibble = (state == lcd_pkg::snd_high_off || state == lcd_pkg::snd_high_on)
                    ? byte_q[i2c_pkg::BYTE_W-1:i2c_pkg::BYTE_W/2]
                    : byte_q[i2c_pkg::BYTE_W/2-1:0];
    assign ctrl   = (state == lcd_pkg::snd_high_on || state == lcd_pkg::snd_low_on)
                    ? lcd_pkg::CTRL_ENABLE : lcd_pkg::CTRL_DISABLE;

    assign req.addr  = addr_q;
    assign req.data  = {nibble, ctrl, rs_q};
    assign req.start = start_q;
    assign busy      = (state != lcd_pkg::snd_idle);

    // the master must have finished the previous frame
    a_start_in_frame: assert property (@(posedge clk) disable iff (reset_p)
        req.start |-> (state != lcd_pkg::snd_idle && !req.busy))
        else $error("frame strobe while idle or while the master is busy");

    a_frames_per_byte: assert property (@(posedge clk) disable iff (reset_p)
        $fell(busy) |-> (frame_cnt == lcd_pkg::FRAMES_DONE))
        else $error("wrong frame count for one byte");

endmodule

//--- source/lcd_i2c_top.sv
module lcd_i2c_top (
    input  logic                       clk,
    input  logic                       reset_p,
    input  logic [i2c_pkg::ADDR_W-1:0] addr,
    input  logic [i2c_pkg::BYTE_W-1:0] send_byte,
    input  logic                       rs,
    input  logic                       send,
    output logic                       scl,
    output logic                       sda,
    output logic                       busy
);

    logic usec;

    // sender to master request channel
    i2c_req_if req_bus ();

    usec_tick u_usec_tick (
        .clk     (clk),
        .reset_p (reset_p),
        .usec    (usec)
    );

    lcd_byte_sender u_sender (
        .clk       (clk),
        .reset_p   (reset_p),
        .usec      (usec),
        .send      (send),
        .send_byte (send_byte),
        .rs        (rs),
        .addr      (addr),
        .req       (req_bus.sender),
        .busy      (busy)
    );

    i2c_master u_master (
        .clk     (clk),
        .reset_p (reset_p),
        .usec    (usec),
        .req     (req_bus.master),
        .scl     (scl),
        .sda     (sda)
    );

endmodule

//--- sim/i2c_bus_monitor.sv
module i2c_bus_monitor (
    input logic clk,
    input logic scl,
    input logic sda
);
    timeunit 1ns;
    timeprecision 1ps;

    // event kind in bits 9:8, byte value in bits 7:0
    localparam logic [1:0] EV_BYTE  = 2'd0;
    localparam logic [1:0] EV_START = 2'd1;
    localparam logic [1:0] EV_STOP  = 2'd2;
    localparam int LOW_CLKS = i2c_pkg::SCL_HALF_USEC * i2c_pkg::CLKS_PER_USEC;

    logic [9:0] events [$];
    int         timing_errs;

    logic       scl_q;
    logic       sda_q;
    logic       in_frame;
    logic [8:0] shift;
    int         bit_cnt;
    int         low_cnt;

    initial begin
        scl_q       = 1'b1;
        sda_q       = 1'b1;
        in_frame    = 1'b0;
        shift       = '0;
        bit_cnt     = 0;
        low_cnt     = 0;
        timing_errs = 0;
    end

    always @(posedge clk) begin
        // start and stop, sda moving while scl stays high
        if (scl_q && scl && sda_q && !sda) begin
            events.push_back({EV_START, 8'h00});
            in_frame = 1'b1;
            bit_cnt  = 0;
        end else if (scl_q && scl && !sda_q && sda) begin
            events.push_back({EV_STOP, 8'h00});
            in_frame = 1'b0;
            bit_cnt  = 0;
        end
        // nine bits per group, the ack slot is dropped
        if (!scl_q && scl && in_frame) begin
            shift   = {shift[7:0], sda};
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 9) begin
                events.push_back({EV_BYTE, shift[8:1]});
                bit_cnt = 0;
            end
        end
        // every low phase should be one full half period
        if (!scl) begin
            low_cnt = low_cnt + 1;
        end else if (!scl_q) begin
            if (low_cnt != LOW_CLKS) timing_errs = timing_errs + 1;
            low_cnt = 0;
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

//--- sim/tb_lcd_i2c.sv
module tb_lcd_i2c;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 20;
    localparam int BYTE_USEC    = lcd_pkg::FRAMES_PER_BYTE * lcd_pkg::FRAME_USEC;
    localparam int BYTE_CLKS    = BYTE_USEC * i2c_pkg::CLKS_PER_USEC;
    localparam int IDLE_LIMIT   = BYTE_CLKS + 2 * i2c_pkg::CLKS_PER_USEC;
    localparam int NUM_SENDS    = 13;
    localparam int WATCHDOG_NS  = NUM_SENDS * BYTE_CLKS * 2 * CLK_PERIOD;
    localparam int EV_PER_FRAME = 4;
    localparam logic [1:0] EV_BYTE  = 2'd0;
    localparam logic [1:0] EV_START = 2'd1;
    localparam logic [1:0] EV_STOP  = 2'd2;

    logic                       clk;
    logic                       reset_p;
    logic [i2c_pkg::ADDR_W-1:0] addr;
    logic [i2c_pkg::BYTE_W-1:0] send_byte;
    logic                       rs;
    logic                       send;
    logic                       scl;
    logic                       sda;
    logic                       busy;

    int error_count  = 0;
    int test_errs    = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int sent_bytes   = 0;

    lcd_i2c_top uut (
        .clk       (clk),
        .reset_p   (reset_p),
        .addr      (addr),
        .send_byte (send_byte),
        .rs        (rs),
        .send      (send),
        .scl       (scl),
        .sda       (sda),
        .busy      (busy)
    );

    i2c_bus_monitor bus_mon (
        .clk (clk),
        .scl (scl),
        .sda (sda)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            error_count++;
            test_errs++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %-28s ok", name);
        end else begin
            $display("test %-28s failed with %0d errors", name, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    // expander byte: nibble, backlight/en/rw, rs
    function automatic logic [7:0] frame_data(input logic [3:0] nib, input logic [2:0] ctrl,
                                              input logic r);
        return {nib, ctrl, r};
    endfunction

    task automatic pulse_send(input logic [6:0] a, input logic [7:0] b, input logic r);
        addr      = a;
        send_byte = b;
        rs        = r;
        send      = 1'b1;
        @(negedge clk);
        send = 1'b0;
    endtask

    task automatic wait_until_idle(output int cycles);
        cycles = 0;
        while (busy && cycles < IDLE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            $display("busy still high after %0d cycles", cycles);
            error_count++;
            test_errs++;
        end
    endtask

    task automatic compare_frames(input int first, input logic [6:0] a,
                                  input logic [7:0] b, input logic r);
        logic [7:0] exp_data [lcd_pkg::FRAMES_PER_BYTE];
        int         idx;
        exp_data[0] = frame_data(b[7:4], lcd_pkg::CTRL_DISABLE, r);
        exp_data[1] = frame_data(b[7:4], lcd_pkg::CTRL_ENABLE, r);
        exp_data[2] = frame_data(b[3:0], lcd_pkg::CTRL_DISABLE, r);
        exp_data[3] = frame_data(b[3:0], lcd_pkg::CTRL_ENABLE, r);
        exp_data[4] = frame_data(b[3:0], lcd_pkg::CTRL_DISABLE, r);
        check_value("event count", bus_mon.events.size(),
                    first + lcd_pkg::FRAMES_PER_BYTE * EV_PER_FRAME);
        if (bus_mon.events.size() < first + lcd_pkg::FRAMES_PER_BYTE * EV_PER_FRAME) return;
        for (int f = 0; f < lcd_pkg::FRAMES_PER_BYTE; f++) begin
            idx = first + f * EV_PER_FRAME;
            check_value($sformatf("frame %0d start", f), bus_mon.events[idx], {EV_START, 8'h00});
            check_value($sformatf("frame %0d addr", f), bus_mon.events[idx + 1],
                        {EV_BYTE, a, 1'b0});
            check_value($sformatf("frame %0d data", f), bus_mon.events[idx + 2],
                        {EV_BYTE, exp_data[f]});
            check_value($sformatf("frame %0d stop", f), bus_mon.events[idx + 3], {EV_STOP, 8'h00});
        end
    endtask

    task automatic transfer_byte(input logic [6:0] a, input logic [7:0] b, input logic r,
                                 output int first);
        int cycles;
        first = bus_mon.events.size();
        pulse_send(a, b, r);
        wait_until_idle(cycles);
        compare_frames(first, a, b, r);
        sent_bytes++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic verify_reset_state();
        check_value("scl", scl, 1);
        check_value("sda", sda, 1);
        check_value("busy", busy, 0);
        report_test("reset state");
    endtask

    task automatic byte_with_rs_low();
        int first;
        transfer_byte(7'h27, 8'hA5, 1'b0, first);
        report_test("byte with rs low");
    endtask

    task automatic byte_with_rs_high();
        int first;
        transfer_byte(7'h27, 8'hA5, 1'b1, first);
        for (int f = 0; f < lcd_pkg::FRAMES_PER_BYTE; f++) begin
            check_value($sformatf("frame %0d rs bit", f),
                        bus_mon.events[first + f * EV_PER_FRAME + 2][0], 1);
        end
        report_test("byte with rs high");
    endtask

    task automatic busy_window_and_ignored_send();
        int first;
        int cycles;
        int total;
        first = bus_mon.events.size();
        check_value("busy before send", busy, 0);
        pulse_send(7'h3F, 8'h5C, 1'b0);
        check_value("busy after send", busy, 1);
        // second strobe lands in the first frame and must be dropped
        repeat (3 * i2c_pkg::CLKS_PER_USEC) @(negedge clk);
        pulse_send(7'h12, 8'hFF, 1'b1);
        wait_until_idle(cycles);
        total = cycles + 3 * i2c_pkg::CLKS_PER_USEC + 2;
        // usec phase moves the edge by up to a microsecond either way
        if (total < BYTE_CLKS - i2c_pkg::CLKS_PER_USEC ||
            total > BYTE_CLKS + i2c_pkg::CLKS_PER_USEC) begin
            $display("busy dropped after %0d cycles, outside the expected window", total);
            error_count++;
            test_errs++;
        end
        compare_frames(first, 7'h3F, 8'h5C, 1'b0);
        sent_bytes++;
        report_test("busy window, ignored send");
    endtask

    task automatic random_bytes();
        logic [6:0] a;
        logic [7:0] b;
        logic       r;
        int         first;
        for (int i = 0; i < 10; i++) begin
            a = 7'($urandom);
            b = 8'($urandom);
            r = 1'($urandom);
            transfer_byte(a, b, r, first);
        end
        report_test("random bytes");
    endtask

    task automatic bus_conditions();
        int         starts;
        int         stops;
        int         bytes_in_frame;
        logic [9:0] ev;
        starts         = 0;
        stops          = 0;
        bytes_in_frame = 0;
        for (int i = 0; i < bus_mon.events.size(); i++) begin
            ev = bus_mon.events[i];
            if (ev[9:8] == EV_START) begin
                starts++;
                bytes_in_frame = 0;
            end else if (ev[9:8] == EV_STOP) begin
                stops++;
                check_value($sformatf("bytes before stop %0d", stops), bytes_in_frame, 2);
            end else begin
                bytes_in_frame++;
            end
        end
        check_value("start count", starts, sent_bytes * lcd_pkg::FRAMES_PER_BYTE);
        check_value("stop count", stops, sent_bytes * lcd_pkg::FRAMES_PER_BYTE);
        check_value("scl low phase errors", bus_mon.timing_errs, 0);
        report_test("start and stop conditions");
    endtask

    initial begin
        void'($urandom(23482));
        reset_p   = 1'b1;
        send      = 1'b0;
        addr      = '0;
        send_byte = '0;
        rs        = 1'b0;
        repeat (2) @(negedge clk);
        reset_p = 1'b0;
        @(negedge clk);

        verify_reset_state();
        byte_with_rs_low();
        byte_with_rs_high();
        busy_window_and_ignored_send();
        random_bytes();
        bus_conditions();

        $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- lcd_i2c.f
source/i2c_pkg.sv
source/lcd_pkg.sv
source/i2c_req_if.sv
source/usec_tick.sv
source/i2c_master.sv
source/lcd_byte_sender.sv
source/lcd_i2c_top.sv
sim/i2c_bus_monitor.sv
sim/tb_lcd_i2c.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_lcd_i2c
FILELIST = lcd_i2c.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = Result: PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation, output in $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
